/* project.f */
hw/mem_pkg.sv
hw/mem_except_check.sv
hw/mem_access.sv
hw/data_sram.sv
hw/mem_ctrl.sv
hw/mem_stage.sv
tb/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - hw/mem_pkg.sv
  - hw/mem_except_check.sv
  - hw/mem_access.sv
  - hw/data_sram.sv
  - hw/mem_ctrl.sv
  - hw/mem_stage.sv
  - target: test
    files:
      - tb/tb_mem_stage.sv

/* tb/tb_mem_stage.sv */
module tb_mem_stage;

    localparam int TIMEOUT = 20;

    logic             clk = 1'b0;
    logic             rst;
    logic             stall;
    mem_pkg::m_slot_t m_master;
    mem_pkg::m_slot_t m_slave;
    mem_pkg::wb_t     w_master;
    mem_pkg::wb_t     w_slave;

    logic [31:0] ref_mem [mem_pkg::DSRAM_WORDS];
    integer      seed = 94;
    int          captures = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    mem_stage dut (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .m_master (m_master),
        .m_slave  (m_slave),
        .w_master (w_master),
        .w_slave  (w_slave)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (!rst && !stall) begin
            captures <= captures + 1; // One count per edge that loads the writeback register.
        end
    end

    // ========================================
    // Reference model
    // ========================================

    function automatic mem_pkg::m_slot_t make_slot(input logic [5:0] op, input logic [31:0] addr,
                                                   input logic [31:0] wdata);
        mem_pkg::m_slot_t s;
        s        = '0;
        s.valid  = 1'b1;
        s.op     = op;
        s.result = addr;
        s.wdata  = wdata;
        return s;
    endfunction

    function automatic mem_pkg::wb_t make_wb(input logic valid, input logic [31:0] result,
                                             input mem_pkg::except_t exc,
                                             input logic [31:0] badvaddr);
        mem_pkg::wb_t w;
        w.valid    = valid;
        w.result   = result;
        w.exc      = exc;
        w.badvaddr = badvaddr;
        return w;
    endfunction

    task automatic ref_store(input logic [5:0] op, input logic [31:0] addr,
                             input logic [31:0] data);
        int shift;
        shift = 8 * addr[1:0];
        if (op == mem_pkg::OP_SW) begin
            ref_mem[addr[9:2]] = data;
        end else if (op == mem_pkg::OP_SH) begin
            ref_mem[addr[9:2]][shift +: 16] = data[15:0];
        end else begin
            ref_mem[addr[9:2]][shift +: 8] = data[7:0];
        end
    endtask

    function automatic logic [31:0] ref_load(input logic [5:0] op, input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] lane;
        word = ref_mem[addr[9:2]];
        lane = word >> (8 * addr[1:0]); // Wanted lane ends up in the low bits.
        case (op)
            mem_pkg::OP_LB:  return {{24{lane[7]}}, lane[7:0]};
            mem_pkg::OP_LBU: return {24'h000000, lane[7:0]};
            mem_pkg::OP_LH:  return {{16{lane[15]}}, lane[15:0]};
            mem_pkg::OP_LHU: return {16'h0000, lane[15:0]};
            default:         return word;
        endcase
    endfunction

    // ========================================
    // Checks and stimulus helpers
    // ========================================

    task automatic check_wb(input string name, input mem_pkg::wb_t act, input mem_pkg::wb_t exp,
                            input logic chk_result);
        assert (act.valid === exp.valid) else begin
            $display("error %s.valid expected %h got %h", name, exp.valid, act.valid);
            test_errors++;
        end
        if (exp.valid) begin
            assert (act.exc === exp.exc) else begin
                $display("error %s.exc expected %h got %h", name, exp.exc, act.exc);
                test_errors++;
            end
            assert (act.badvaddr === exp.badvaddr) else begin
                $display("error %s.badvaddr expected %h got %h", name, exp.badvaddr,
                         act.badvaddr);
                test_errors++;
            end
            if (chk_result) begin
                assert (act.result === exp.result) else begin
                    $display("error %s.result expected %h got %h", name, exp.result,
                             act.result);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic await_capture();
        int target;
        int waited;
        target = captures + 1;
        waited = 0;
        while (captures < target && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (captures < target) begin
            $display("timeout waiting for the writeback register to capture a slot");
            $display("Test failed");
            $finish;
        end
    endtask

    // Memory op on the master slot with an ALU op beside it on the slave slot.
    task automatic mem_op(input logic [5:0] op, input logic [31:0] addr, input logic [31:0] data);
        mem_pkg::m_slot_t alu;
        logic [31:0]      alu_value;
        logic             store;
        logic [31:0]      exp_result;
        store      = op inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW};
        exp_result = store ? addr : ref_load(op, addr);
        alu_value  = $random(seed);
        alu        = make_slot(mem_pkg::OP_ALU, alu_value, 32'h0);
        m_master   = make_slot(op, addr, data);
        m_slave    = alu;
        await_capture();
        if (store) begin
            ref_store(op, addr, data);
        end
        check_wb("w_master", w_master, make_wb(1'b1, exp_result, '0, 32'h0), 1'b1);
        check_wb("w_slave", w_slave, make_wb(1'b1, alu_value, '0, 32'h0), 1'b1);
    endtask

    task automatic fault_op(input logic [5:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic load);
        mem_pkg::except_t exc;
        exc      = '0;
        exc.adel = load;
        exc.ades = !load;
        m_master = make_slot(op, addr, data);
        m_slave  = make_slot(mem_pkg::OP_ALU, 32'h1234_5678, 32'h0);
        await_capture();
        check_wb("w_master", w_master, make_wb(1'b1, 32'h0, exc, addr), 1'b0);
        check_wb("w_slave", w_slave, make_wb(1'b0, 32'h0, '0, 32'h0), 1'b1); // Flushed.
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        mem_pkg::m_slot_t slot_m;
        mem_pkg::m_slot_t slot_s;
        mem_pkg::wb_t     exp_m;
        mem_pkg::wb_t     hold_m;
        mem_pkg::wb_t     hold_s;
        logic [31:0]      base;
        logic [31:0]      data;

        rst      = 1'b1;
        stall    = 1'b0;
        m_master = make_slot(mem_pkg::OP_ALU, 32'h0000_1111, 32'h0); // Reset must hide these.
        m_slave  = make_slot(mem_pkg::OP_ALU, 32'h0000_2222, 32'h0);

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            if (i == 7) begin
                rst      = 1'b0; // Idle slots follow, so valid must stay low.
                m_master = '0;
                m_slave  = '0;
            end
            check_wb("w_master", w_master, make_wb(1'b0, 32'h0, '0, 32'h0), 1'b1);
            check_wb("w_slave", w_slave, make_wb(1'b0, 32'h0, '0, 32'h0), 1'b1);
        end
        finish_test("reset");

        for (int n = 0; n < 4; n++) begin
            base = $random(seed) & 32'h0000_03fc;
            data = $random(seed);
            mem_op(mem_pkg::OP_SW, base, data);
            mem_op(mem_pkg::OP_LW, base, 32'h0);
        end
        finish_test("word_round_trip");

        base = $random(seed) & 32'h0000_03fc;
        data = $random(seed);
        mem_op(mem_pkg::OP_SW, base, data);
        for (int off = 0; off < 4; off++) begin
            data = $random(seed);
            mem_op(mem_pkg::OP_SB, base + off, data);
        end
        for (int off = 0; off < 4; off++) begin
            mem_op(mem_pkg::OP_LB, base + off, 32'h0);
            mem_op(mem_pkg::OP_LBU, base + off, 32'h0);
        end
        mem_op(mem_pkg::OP_LW, base, 32'h0);
        for (int off = 0; off < 4; off += 2) begin
            data = $random(seed);
            mem_op(mem_pkg::OP_SH, base + off, data);
            mem_op(mem_pkg::OP_LH, base + off, 32'h0);
            mem_op(mem_pkg::OP_LHU, base + off, 32'h0);
        end
        mem_op(mem_pkg::OP_LW, base, 32'h0);
        finish_test("byte_halfword_lanes");

        base = $random(seed) & 32'h0000_03fc;
        data = $random(seed);
        mem_op(mem_pkg::OP_SW, base, data);
        for (int off = 1; off < 4; off++) begin
            fault_op(mem_pkg::OP_LW, base + off, 32'h0, 1'b1);
        end
        fault_op(mem_pkg::OP_LH, base + 1, 32'h0, 1'b1);
        fault_op(mem_pkg::OP_LHU, base + 3, 32'h0, 1'b1);
        fault_op(mem_pkg::OP_SW, base + 2, ~data, 1'b0);
        fault_op(mem_pkg::OP_SH, base + 1, ~data, 1'b0);
        mem_op(mem_pkg::OP_LW, base, 32'h0);
        finish_test("alignment_errors");

        base = $random(seed) & 32'h0000_03fc;
        data = $random(seed);
        mem_op(mem_pkg::OP_SW, base, data);
        slot_m        = make_slot(mem_pkg::OP_ALU, 32'h0bad_0f10, 32'h0);
        slot_m.exc.ov = 1'b1;
        slot_s        = make_slot(mem_pkg::OP_SW, base, ~data);
        m_master      = slot_m;
        m_slave       = slot_s;
        await_capture();
        exp_m        = make_wb(1'b1, slot_m.result, '0, 32'h0);
        exp_m.exc.ov = 1'b1;
        check_wb("w_master", w_master, exp_m, 1'b1);
        check_wb("w_slave", w_slave, make_wb(1'b0, 32'h0, '0, 32'h0), 1'b1);
        mem_op(mem_pkg::OP_LW, base, 32'h0);
        slot_m.exc = '0;
        m_master   = slot_m;
        m_slave    = slot_s;
        await_capture();
        ref_store(mem_pkg::OP_SW, base, ~data);
        check_wb("w_master", w_master, make_wb(1'b1, slot_m.result, '0, 32'h0), 1'b1);
        check_wb("w_slave", w_slave, make_wb(1'b1, base, '0, 32'h0), 1'b1);
        mem_op(mem_pkg::OP_LW, base, 32'h0);
        finish_test("master_exception");

        base = $random(seed) & 32'h0000_03fc;
        data = $random(seed);
        mem_op(mem_pkg::OP_SW, base, data);
        mem_op(mem_pkg::OP_LW, base, 32'h0); // Leaves load data in w_master, not the address.
        hold_m   = w_master;
        hold_s   = w_slave;
        slot_m   = make_slot(mem_pkg::OP_SW, base, ~data);
        slot_s   = make_slot(mem_pkg::OP_ALU, 32'h5a5a_0001, 32'h0);
        m_master = slot_m;
        m_slave  = slot_s;
        stall    = 1'b1;
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #1;
            assert (w_master === hold_m) else begin
                $display("error w_master expected %h got %h", hold_m, w_master);
                test_errors++;
            end
            assert (w_slave === hold_s) else begin
                $display("error w_slave expected %h got %h", hold_s, w_slave);
                test_errors++;
            end
            assert (dut.u_sram.mem[base[9:2]] === ref_mem[base[9:2]]) else begin
                $display("error sram word expected %h got %h", ref_mem[base[9:2]],
                         dut.u_sram.mem[base[9:2]]);
                test_errors++;
            end
        end
        stall = 1'b0;
        await_capture();
        ref_store(mem_pkg::OP_SW, base, ~data);
        check_wb("w_master", w_master, make_wb(1'b1, base, '0, 32'h0), 1'b1);
        check_wb("w_slave", w_slave, make_wb(1'b1, slot_s.result, '0, 32'h0), 1'b1);
        mem_op(mem_pkg::OP_LW, base, 32'h0);
        finish_test("stall");

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hw/mem_stage.sv */
module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  mem_pkg::m_slot_t m_master,
    input  mem_pkg::m_slot_t m_slave,
    output mem_pkg::wb_t     w_master,
    output mem_pkg::wb_t     w_slave
);

    mem_pkg::m_slot_t   master_chk;
    mem_pkg::m_slot_t   slave_chk;
    logic               master_is_mem;
    logic               slave_is_mem;
    logic               master_bad;
    logic               slave_bad;
    mem_pkg::mem_req_t  req;
    mem_pkg::sram_req_t sram;
    logic [31:0]        sram_rdata;
    logic [31:0]        load_data;

    mem_except_check u_master_check (
        .slot         (m_master),
        .checked      (master_chk),
        .is_mem       (master_is_mem),
        .badvaddr_hit (master_bad)
    );

    mem_except_check u_slave_check (
        .slot         (m_slave),
        .checked      (slave_chk),
        .is_mem       (slave_is_mem),
        .badvaddr_hit (slave_bad)
    );

    mem_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .master        (master_chk),
        .slave         (slave_chk),
        .master_is_mem (master_is_mem),
        .slave_is_mem  (slave_is_mem),
        .master_bad    (master_bad),
        .slave_bad     (slave_bad),
        .load_data     (load_data),
        .req           (req),
        .w_master      (w_master),
        .w_slave       (w_slave)
    );

    mem_access u_access (
        .req        (req),
        .sram_rdata (sram_rdata),
        .sram       (sram),
        .rdata      (load_data)
    );

    data_sram u_sram (
        .clk   (clk),
        .sram  (sram),
        .rdata (sram_rdata)
    );

endmodule

/* hw/mem_ctrl.sv */
module mem_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  mem_pkg::m_slot_t  master,
    input  mem_pkg::m_slot_t  slave,
    input  logic              master_is_mem,
    input  logic              slave_is_mem,
    input  logic              master_bad,
    input  logic              slave_bad,
    input  logic [31:0]       load_data,
    output mem_pkg::mem_req_t req,
    output mem_pkg::wb_t      w_master,
    output mem_pkg::wb_t      w_slave
);

    logic              master_exc;
    logic              slave_exc;
    logic              dual_mem;
    logic              access_en;
    mem_pkg::except_t  slave_exc_bus;
    mem_pkg::m_slot_t  mem_slot;
    mem_pkg::wb_t      master_d;
    mem_pkg::wb_t      slave_d;
    mem_pkg::wb_t      master_q;
    mem_pkg::wb_t      slave_q;
    logic              master_vq;
    logic              slave_vq;

    // ========================================
    // Slot selection and access enable
    // ========================================

    assign master_exc = master.valid && (|master.exc);
    assign dual_mem   = master_is_mem && slave_is_mem; // Issue must never pair these.

    always_comb begin
        slave_exc_bus    = slave.exc;
        slave_exc_bus.ri = slave.exc.ri | dual_mem;
    end

    assign slave_exc = |slave_exc_bus;
    assign mem_slot  = master_is_mem ? master : slave;

    assign access_en = !stall && (master_is_mem ? !master_exc
                                                : (slave_is_mem && !master_exc && !slave_exc));

    always_comb begin
        req.en    = access_en;
        req.op    = mem_slot.op;
        req.addr  = mem_slot.result;
        req.wdata = mem_slot.wdata;
    end

    // ========================================
    // Writeback register
    // ========================================

    always_comb begin
        master_d.valid    = master.valid;
        master_d.result   = (master_is_mem && mem_pkg::is_load(master.op)) ? load_data
                                                                          : master.result;
        master_d.exc      = master.exc;
        master_d.badvaddr = master_bad ? master.result : 32'h0000_0000;

        slave_d.valid    = slave.valid && !master_exc; // Flushed behind a faulting master.
        slave_d.result   = (slave_is_mem && !dual_mem && mem_pkg::is_load(slave.op)) ? load_data
                                                                                   : slave.result;
        slave_d.exc      = slave_exc_bus;
        slave_d.badvaddr = slave_bad ? slave.result : 32'h0000_0000;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            master_vq <= 1'b0;
            slave_vq  <= 1'b0;
        end else if (!stall) begin
            master_vq <= master_d.valid;
            slave_vq  <= slave_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            master_q <= master_d;
            slave_q  <= slave_d;
        end
    end

    always_comb begin
        w_master       = master_q;
        w_master.valid = master_vq;
        w_slave        = slave_q;
        w_slave.valid  = slave_vq;
    end

endmodule

/* hw/data_sram.sv */
module data_sram (
    input  logic               clk,
    input  mem_pkg::sram_req_t sram,
    output logic [31:0]        rdata
);

    logic [31:0] mem [mem_pkg::DSRAM_WORDS];

    assign rdata = mem[sram.index]; // Read is asynchronous.

    always_ff @(posedge clk) begin
        if (sram.en) begin
            for (int i = 0; i < 4; i++) begin
                if (sram.wen[i]) begin
                    mem[sram.index][8*i +: 8] <= sram.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* hw/mem_access.sv */
module mem_access (
    input  mem_pkg::mem_req_t  req,
    input  logic [31:0]        sram_rdata,
    output mem_pkg::sram_req_t sram,
    output logic [31:0]        rdata
);

    logic [1:0]  lane;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign lane = req.addr[1:0];

    // ========================================
    // Load lane selection
    // ========================================

    always_comb begin
        case (lane)
            2'b00:   rd_byte = sram_rdata[7:0];
            2'b01:   rd_byte = sram_rdata[15:8];
            2'b10:   rd_byte = sram_rdata[23:16];
            default: rd_byte = sram_rdata[31:24];
        endcase
    end

    assign rd_half = lane[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        case (req.op)
            mem_pkg::OP_LW: begin
                rdata = sram_rdata;
            end
            mem_pkg::OP_LB: begin
                rdata = {{24{rd_byte[7]}}, rd_byte};
            end
            mem_pkg::OP_LBU: begin
                rdata = {24'h000000, rd_byte};
            end
            mem_pkg::OP_LH: begin
                rdata = {{16{rd_half[15]}}, rd_half};
            end
            mem_pkg::OP_LHU: begin
                rdata = {16'h0000, rd_half};
            end
            default: begin
                rdata = 32'h0000_0000;
            end
        endcase
    end

    // ========================================
    // Store lanes and write enables
    // ========================================

    always_comb begin
        sram.en    = req.en;
        sram.index = req.addr[mem_pkg::DSRAM_AW+1:2];
        sram.wen   = 4'b0000;
        sram.wdata = 32'h0000_0000;
        case (req.op)
            mem_pkg::OP_SW: begin
                sram.wdata = req.wdata;
                sram.wen   = {4{lane == 2'b00}};
            end
            mem_pkg::OP_SH: begin
                sram.wdata = {2{req.wdata[15:0]}}; // Same half in both lanes.
                if (!lane[0]) begin
                    sram.wen = lane[1] ? 4'b1100 : 4'b0011;
                end
            end
            mem_pkg::OP_SB: begin
                sram.wdata = {4{req.wdata[7:0]}};
                sram.wen   = 4'b0001 << lane;
            end
            default: begin
                sram.wen = 4'b0000;
            end
        endcase
        if (!req.en) begin
            sram.wen = 4'b0000; // A suppressed access never writes.
        end
    end

endmodule

/* hw/mem_except_check.sv */
module mem_except_check (
    input  mem_pkg::m_slot_t slot,
    output mem_pkg::m_slot_t checked,
    output logic             is_mem,
    output logic             badvaddr_hit
);

    logic load;
    logic store;
    logic misaligned;

    assign load  = mem_pkg::is_load(slot.op);
    assign store = mem_pkg::is_store(slot.op);

    always_comb begin
        case (slot.op)
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: begin
                misaligned = slot.result[0]; // Halfwords need an even address.
            end
            mem_pkg::OP_LW, mem_pkg::OP_SW: begin
                misaligned = |slot.result[1:0];
            end
            default: begin
                misaligned = 1'b0; // Bytes can sit anywhere.
            end
        endcase
    end

    assign is_mem       = slot.valid && (load || store);
    assign badvaddr_hit = is_mem && misaligned;

    // Address errors are merged on top of whatever earlier stages reported.
    always_comb begin
        checked          = slot;
        checked.exc.adel = slot.exc.adel | (badvaddr_hit & load);
        checked.exc.ades = slot.exc.ades | (badvaddr_hit & store);
    end

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

    // ========================================
    // Operation codes
    // ========================================

    localparam int OP_W = 6;

    localparam logic [OP_W-1:0] OP_ALU = 6'h00; // Any instruction that leaves memory alone.
    localparam logic [OP_W-1:0] OP_LB  = 6'h20;
    localparam logic [OP_W-1:0] OP_LH  = 6'h21;
    localparam logic [OP_W-1:0] OP_LW  = 6'h23;
    localparam logic [OP_W-1:0] OP_LBU = 6'h24;
    localparam logic [OP_W-1:0] OP_LHU = 6'h25;
    localparam logic [OP_W-1:0] OP_SB  = 6'h28;
    localparam logic [OP_W-1:0] OP_SH  = 6'h29;
    localparam logic [OP_W-1:0] OP_SW  = 6'h2b;

    // ========================================
    // Data SRAM geometry
    // ========================================

    localparam int DSRAM_WORDS = 256;
    localparam int DSRAM_AW    = 8; // Address bits 9:2 pick the word.

    // ========================================
    // Buses
    // ========================================

    typedef struct packed {
        logic adel;
        logic ades;
        logic ov;
        logic sys;
        logic brk;
        logic ri;
    } except_t;

    typedef struct packed {
        logic            valid;
        logic [OP_W-1:0] op;
        logic [31:0]     result; // Effective address for loads and stores.
        logic [31:0]     wdata;
        except_t         exc;
    } m_slot_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        except_t     exc;
        logic [31:0] badvaddr;
    } wb_t;

    typedef struct packed {
        logic            en;
        logic [OP_W-1:0] op;
        logic [31:0]     addr;
        logic [31:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic                en;
        logic [3:0]          wen;
        logic [DSRAM_AW-1:0] index;
        logic [31:0]         wdata;
    } sram_req_t;

    function automatic logic is_load(input logic [OP_W-1:0] op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store(input logic [OP_W-1:0] op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage
